/* rtl/wiscPkg.sv */
// Shared definitions for the 16-bit multicycle teaching core
// Holds the data width, opcode and ALU operation encodings, and the
// instruction word with its four field views
// Compile before any module; modules import it inside their bodies
package wiscPkg;

   localparam int wordW = 16;            // Data and address width

   typedef logic [2:0] regAddrT;         // Index into the eight registers

   typedef enum logic [4:0] {
      HALT  = 5'b00000,
      NOP   = 5'b00001,
      J     = 5'b00100,                  // pc + 2 + disp11
      JR    = 5'b00101,                  // rs + imm8
      ADDI  = 5'b01000,
      SUBI  = 5'b01001,
      XORI  = 5'b01010,
      ANDNI = 5'b01011,
      BEQZ  = 5'b01100,
      BNEZ  = 5'b01101,
      BLTZ  = 5'b01110,
      BGEZ  = 5'b01111,
      RALU  = 5'b11011                   // R-format group, func picks the op
   } opcodeT;

   typedef enum logic [2:0] {
      aluAdd,                            // A + B
      aluSub,                            // B - A
      aluXor,
      aluAndn,                           // A & ~B
      aluPassA                           // Branch test and JR base
   } aluOpT;

   typedef struct packed {
      opcodeT     op;
      regAddrT    rs;
      regAddrT    rd;
      logic [4:0] imm5;
   } iFormT;

   typedef struct packed {
      opcodeT     op;
      regAddrT    rs;
      regAddrT    rt;
      regAddrT    rd;
      logic [1:0] func;
   } rFormT;

   typedef struct packed {
      opcodeT     op;
      regAddrT    rs;
      logic [7:0] imm8;
   } bFormT;

   typedef struct packed {
      opcodeT      op;
      logic [10:0] disp11;
   } jFormT;

   // Same 16 bits, decoded per opcode
   typedef union packed {
      iFormT iForm;
      rFormT rForm;
      bFormT bForm;
      jFormT jForm;
   } instrU;

endpackage

/* rtl/alu.sv */
// Combinational ALU for the core
// Add, reverse subtract, xor, and-not, and a pass-through of A
// A is always rs; B is rt or the extended immediate
`timescale 1ns/100ps

module alu (
   input  logic [wiscPkg::wordW-1:0]   inA,
   input  logic [wiscPkg::wordW-1:0]   inB,
   input  wiscPkg::aluOpT              aluOp,
   output logic [wiscPkg::wordW-1:0]   aluOut
);
   import wiscPkg::*;

   always_comb begin
      case (aluOp)
         aluAdd: begin
            aluOut = inA + inB;
         end
         aluSub: begin
            aluOut = inB - inA;           // SUBI and SUB subtract rs
         end
         aluXor: begin
            aluOut = inA ^ inB;
         end
         aluAndn: begin
            aluOut = inA & ~inB;
         end
         default: begin
            aluOut = inA;                 // aluPassA for branch tests and JR
         end
      endcase
   end

endmodule

/* rtl/regFile.sv */
// Eight 16-bit architectural registers
// Two combinational read ports for rs and rt, one write port at the clock edge
// All registers clear on reset
`timescale 1ns/100ps

module regFile (
   input  logic                        clk,
   input  logic                        rst,
   input  wiscPkg::regAddrT            rdAddrA,
   input  wiscPkg::regAddrT            rdAddrB,
   output logic [wiscPkg::wordW-1:0]   rdDataA,
   output logic [wiscPkg::wordW-1:0]   rdDataB,
   input  logic                        wrEn,
   input  wiscPkg::regAddrT            wrAddr,
   input  logic [wiscPkg::wordW-1:0]   wrData
);
   import wiscPkg::*;

   logic [wordW-1:0] regs [8];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // No bypass needed, a write always lands before the next read
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

endmodule

/* rtl/pcCounter.sv */
// Program counter register
// Starts at resetPc, and on each pcStep strobe either loads the target
// or moves to the next 16-bit word
`timescale 1ns/100ps

module pcCounter #(
   parameter logic [wiscPkg::wordW-1:0] resetPc = '0
) (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        pcStep,
   input  logic                        pcLoad,
   input  logic [wiscPkg::wordW-1:0]   target,
   output logic [wiscPkg::wordW-1:0]   pc
);
   import wiscPkg::*;

   logic [wordW-1:0] pcNext;

   always_comb begin
      if (pcLoad)
         pcNext = target;                 // Taken branch or jump
      else
         pcNext = pc + wordW'(2);         // Sequential, byte addressed
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= resetPc;
      end else if (pcStep) begin
         pc <= pcNext;
      end
   end

endmodule

/* rtl/execute.sv */
// Execute stage
// Extends the immediate, picks the ALU operands, tests the branch condition
// on the ALU output and adds the branch or jump target
// Result, taken and target are held from the execute cycle into writeback
`timescale 1ns/100ps

module execute (
   input  logic                        clk,
   input  wiscPkg::instrU              instr,
   input  logic [wiscPkg::wordW-1:0]   pc,
   input  logic [wiscPkg::wordW-1:0]   rsData,
   input  logic [wiscPkg::wordW-1:0]   rtData,
   input  wiscPkg::aluOpT              aluOp,
   input  logic                        exLatch,
   output logic [wiscPkg::wordW-1:0]   result,
   output logic                        taken,
   output logic [wiscPkg::wordW-1:0]   target
);
   import wiscPkg::*;

   logic [wordW-1:0] extImm;              // Offset for the ALU and the target adder
   logic [wordW-1:0] operandB;
   logic [wordW-1:0] aluOut;
   logic [wordW-1:0] targetBase;
   logic             useImm;
   logic             isJump;
   logic             branchCond;

   always_comb begin
      extImm     = {{(wordW-5){instr.iForm.imm5[4]}}, instr.iForm.imm5};
      useImm     = 1'b0;
      isJump     = 1'b0;
      branchCond = 1'b0;
      case (instr.iForm.op)
         ADDI, SUBI: useImm = 1'b1;
         XORI, ANDNI: begin
            extImm = {{(wordW-5){1'b0}}, instr.iForm.imm5};   // Logical ops zero extend
            useImm = 1'b1;
         end
         BEQZ, BNEZ, BLTZ, BGEZ: begin
            extImm = {{(wordW-8){instr.bForm.imm8[7]}}, instr.bForm.imm8};
            case (instr.bForm.op)         // ALU passes rs straight through
               BEQZ:    branchCond = ~|aluOut;
               BNEZ:    branchCond = |aluOut;
               BLTZ:    branchCond = aluOut[wordW-1];   // Sign bit set
               default: branchCond = ~aluOut[wordW-1];
            endcase
         end
         JR: begin
            extImm = {{(wordW-8){instr.bForm.imm8[7]}}, instr.bForm.imm8};
            isJump = 1'b1;
         end
         J: begin
            extImm = {{(wordW-11){instr.jForm.disp11[10]}}, instr.jForm.disp11};
            isJump = 1'b1;
         end
         default: ;
      endcase
   end

   assign operandB   = useImm ? extImm : rtData;
   assign targetBase = (instr.iForm.op == JR) ? aluOut : (pc + wordW'(2));

   alu alu_i (
      .inA    (rsData),
      .inB    (operandB),
      .aluOp  (aluOp),
      .aluOut (aluOut)
   );

   always_ff @(posedge clk) begin
      if (exLatch) begin
         result <= aluOut;
         taken  <= branchCond | isJump;
         target <= targetBase + extImm;
      end
   end

endmodule

/* rtl/controlFsm.sv */
// Phase sequencer: fetch, execute, writeback, and a halt state
// Owns the instruction register and decodes ALU op, write enable and destination
// Phase controls are single-cycle strobes
`timescale 1ns/100ps

module controlFsm (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [wiscPkg::wordW-1:0]   instrIn,
   output wiscPkg::instrU              instrReg,
   output logic                        exLatch,
   output logic                        wbEn,
   output wiscPkg::regAddrT            wbReg,
   output wiscPkg::aluOpT              aluOp,
   output logic                        pcStep,
   output logic                        halted
);
   import wiscPkg::*;

   localparam logic [1:0] sFetch = 2'd0;
   localparam logic [1:0] sExec  = 2'd1;
   localparam logic [1:0] sWb    = 2'd2;
   localparam logic [1:0] sHalt  = 2'd3;

   logic [1:0] state;
   logic       writesReg;                 // ALU instruction with a destination

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= sFetch;
      end else begin
         case (state)
            sFetch: state <= sExec;
            sExec: begin
               if (instrReg.iForm.op == HALT)
                  state <= sHalt;         // Stops before writeback
               else
                  state <= sWb;
            end
            sWb:     state <= sFetch;
            default: state <= sHalt;      // Held until reset
         endcase
      end
   end

   // Capture the fetched word at the end of the fetch cycle
   always_ff @(posedge clk) begin
      if (state == sFetch) begin
         instrReg <= instrIn;
      end
   end

   always_comb begin
      aluOp     = aluPassA;               // Branches, jumps, NOP, HALT
      writesReg = 1'b0;
      wbReg     = instrReg.iForm.rd;
      case (instrReg.iForm.op)
         ADDI: begin
            aluOp     = aluAdd;
            writesReg = 1'b1;
         end
         SUBI: begin
            aluOp     = aluSub;           // imm - rs
            writesReg = 1'b1;
         end
         XORI: begin
            aluOp     = aluXor;
            writesReg = 1'b1;
         end
         ANDNI: begin
            aluOp     = aluAndn;
            writesReg = 1'b1;
         end
         RALU: begin
            writesReg = 1'b1;
            wbReg     = instrReg.rForm.rd;   // rd moves down in R-format
            case (instrReg.rForm.func)
               2'd0:    aluOp = aluAdd;
               2'd1:    aluOp = aluSub;      // rt - rs
               2'd2:    aluOp = aluXor;
               default: aluOp = aluAndn;
            endcase
         end
         default: ;
      endcase
   end

   assign exLatch = (state == sExec);
   assign wbEn    = (state == sWb) && writesReg;
   assign pcStep  = (state == sWb);       // Every retired instruction moves the pc
   assign halted  = (state == sHalt);

endmodule

/* rtl/wiscCore.sv */
// Top level of the multicycle core
// Connects the phase FSM, program counter, register file and execute stage
// Instruction fetch is a plain address out with a combinational word back;
// the write port of the register file is brought out for observation
`timescale 1ns/100ps

module wiscCore #(
   parameter logic [wiscPkg::wordW-1:0] resetPc = '0   // Must be even
) (
   input  logic                        clk,
   input  logic                        rst,
   output logic [wiscPkg::wordW-1:0]   instrAddr,
   input  logic [wiscPkg::wordW-1:0]   instr,
   output logic                        wbEn,
   output wiscPkg::regAddrT            wbReg,
   output logic [wiscPkg::wordW-1:0]   wbData,
   output logic                        halted
);
   import wiscPkg::*;

   instrU            instrReg;
   aluOpT            aluOp;
   logic             exLatch;
   logic             pcStep;
   logic             taken;
   logic [wordW-1:0] target;
   logic [wordW-1:0] rsData;
   logic [wordW-1:0] rtData;

   controlFsm fsm_i (
      .clk      (clk),
      .rst      (rst),
      .instrIn  (instr),
      .instrReg (instrReg),
      .exLatch  (exLatch),
      .wbEn     (wbEn),
      .wbReg    (wbReg),
      .aluOp    (aluOp),
      .pcStep   (pcStep),
      .halted   (halted)
   );

   pcCounter #(.resetPc(resetPc)) pc_i (
      .clk    (clk),
      .rst    (rst),
      .pcStep (pcStep),
      .pcLoad (taken),                    // Taken branch or jump
      .target (target),
      .pc     (instrAddr)                 // Fetch address is the pc itself
   );

   regFile regs_i (
      .clk     (clk),
      .rst     (rst),
      .rdAddrA (instrReg.rForm.rs),       // rs sits at the same bits in every view
      .rdAddrB (instrReg.rForm.rt),
      .rdDataA (rsData),
      .rdDataB (rtData),
      .wrEn    (wbEn),
      .wrAddr  (wbReg),
      .wrData  (wbData)
   );

   execute ex_i (
      .clk     (clk),
      .instr   (instrReg),
      .pc      (instrAddr),
      .rsData  (rsData),
      .rtData  (rtData),
      .aluOp   (aluOp),
      .exLatch (exLatch),
      .result  (wbData),
      .taken   (taken),
      .target  (target)
   );

endmodule

/* test/wiscCoreTb.sv */
// Testbench for the multicycle core
// Runs a short program from a case ROM, tracks a shadow pc and register file,
// and checks fetch address, register writes and halt with concurrent assertions
// Prints one line per test section, then the counts and the verdict
`timescale 1ns/100ps

module wiscCoreTb;
   import wiscPkg::*;

   localparam logic [15:0] startPc = 16'h0040;
   localparam int progLen = 31;                       // Words in the ROM program
   localparam int timeoutCycles = progLen * 3 + 20;

   logic        clk;
   logic        rst;
   logic [15:0] instr;
   logic [15:0] instrAddr;
   logic        wbEn;
   regAddrT     wbReg;
   logic [15:0] wbData;
   logic        halted;

   logic [15:0] lfsr;
   logic [7:0]  immPool [6];                          // Random imm5 values for ALU tests
   int          cycleCount;
   int          errCount;
   int          errMark;
   int          passCount;
   int          failCount;

   // Reference model state
   logic [1:0]  phase;                                // 0 fetch, 1 execute, 2 writeback
   logic [15:0] expPc;
   logic        haltModel;
   logic [15:0] shadow [8];
   logic [15:0] curWord;
   logic [15:0] rsVal;
   logic [15:0] rtVal;
   logic [15:0] seqPc;
   logic [15:0] sImm5;
   logic [15:0] zImm5;
   logic [15:0] sImm8;
   logic [15:0] sImm11;
   logic [4:0]  op;
   logic        modelWrite;
   logic [2:0]  modelReg;
   logic [15:0] modelData;
   logic [15:0] modelNext;
   logic        expWrite;

   wiscCore #(.resetPc(startPc)) dut_i (
      .clk       (clk),
      .rst       (rst),
      .instrAddr (instrAddr),
      .instr     (instr),
      .wbEn      (wbEn),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .halted    (halted)
   );

   always #4 clk = ~clk;                              // 8 ns period

   // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;
      return n;
   endfunction

   task automatic drawBits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[6:0], lfsr[0]};                    // One step per bit taken
         lfsr = lfsrNext(lfsr);
      end
   endtask

   function automatic logic [15:0] immWord(input logic [4:0] o, input logic [2:0] rs,
                                           input logic [2:0] rd, input logic [4:0] imm);
      return {o, rs, rd, imm};
   endfunction

   function automatic logic [15:0] regWord(input logic [2:0] rs, input logic [2:0] rt,
                                           input logic [2:0] rd, input logic [1:0] func);
      return {RALU, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] branchWord(input logic [4:0] o, input logic [2:0] rs,
                                              input logic [7:0] imm8);
      return {o, rs, imm8};
   endfunction

   function automatic logic [15:0] jumpWord(input logic [10:0] disp);
      return {J, disp};
   endfunction

   // Program ROM holding words from 0040 up
   function automatic logic [15:0] romWord(input logic [15:0] addr);
      case (addr)
         16'h0040: return immWord(ADDI, 3'd0, 3'd1, immPool[0][4:0]);
         16'h0042: return immWord(ADDI, 3'd1, 3'd2, immPool[1][4:0]);
         16'h0044: return immWord(SUBI, 3'd2, 3'd3, immPool[2][4:0]);
         16'h0046: return immWord(XORI, 3'd3, 3'd4, immPool[3][4:0]);
         16'h0048: return immWord(ANDNI, 3'd4, 3'd5, immPool[4][4:0]);
         16'h004A: return immWord(SUBI, 3'd0, 3'd6, immPool[5][4:0]);
         16'h004C: return regWord(3'd1, 3'd2, 3'd7, 2'd0);      // add
         16'h004E: return regWord(3'd2, 3'd3, 3'd1, 2'd1);      // r3 - r2
         16'h0050: return regWord(3'd4, 3'd6, 3'd2, 2'd2);      // xor
         16'h0052: return regWord(3'd6, 3'd7, 3'd3, 2'd3);      // andn
         16'h0054: return immWord(ADDI, 3'd0, 3'd5, 5'b11101);  // r5 = -3
         16'h0056: return immWord(ADDI, 3'd0, 3'd6, 5'd5);      // r6 = 5
         16'h0058: return branchWord(BEQZ, 3'd0, 8'd2);         // Taken
         16'h005A: return immWord(ADDI, 3'd0, 3'd7, 5'd1);      // Skipped
         16'h005C: return branchWord(BEQZ, 3'd6, 8'd2);
         16'h005E: return branchWord(BNEZ, 3'd6, 8'd2);         // Taken
         16'h0062: return branchWord(BNEZ, 3'd0, 8'd2);
         16'h0064: return branchWord(BLTZ, 3'd5, 8'd2);         // Taken
         16'h0068: return branchWord(BLTZ, 3'd6, 8'd2);
         16'h006A: return branchWord(BGEZ, 3'd6, 8'd2);         // Taken
         16'h006E: return branchWord(BGEZ, 3'd5, 8'd2);
         16'h0070: return jumpWord(11'd2);
         16'h0074: return immWord(ADDI, 3'd0, 3'd7, 5'd10);
         16'h0076: return branchWord(JR, 3'd7, 8'h70);          // 000A + 70
         16'h0060, 16'h0066, 16'h006C, 16'h0072, 16'h0078, 16'h007A: return {NOP, 11'd0};
         16'h007C: return {HALT, 11'd0};
         default:  return {HALT, addr[15:5] ^ addr[10:0]};      // Stray fetch halts
      endcase
   endfunction

   // Expected outcome of the instruction at the shadow pc
   always_comb begin
      curWord    = romWord(expPc);
      op         = curWord[15:11];
      rsVal      = shadow[curWord[10:8]];
      rtVal      = shadow[curWord[7:5]];
      sImm5      = {{11{curWord[4]}}, curWord[4:0]};
      zImm5      = {11'd0, curWord[4:0]};
      sImm8      = {{8{curWord[7]}}, curWord[7:0]};
      sImm11     = {{5{curWord[10]}}, curWord[10:0]};
      seqPc      = expPc + 16'd2;
      modelWrite = 1'b0;
      modelReg   = curWord[7:5];
      modelData  = '0;
      modelNext  = seqPc;
      case (op)
         ADDI, SUBI, XORI, ANDNI: begin
            modelWrite = 1'b1;
            if (op == ADDI)
               modelData = rsVal + sImm5;
            else if (op == SUBI)
               modelData = sImm5 - rsVal;                    // Reverse subtract
            else if (op == XORI)
               modelData = rsVal ^ zImm5;
            else
               modelData = rsVal & ~zImm5;
         end
         RALU: begin
            modelWrite = 1'b1;
            modelReg   = curWord[4:2];
            case (curWord[1:0])
               2'd0:    modelData = rsVal + rtVal;
               2'd1:    modelData = rtVal - rsVal;
               2'd2:    modelData = rsVal ^ rtVal;
               default: modelData = rsVal & ~rtVal;
            endcase
         end
         BEQZ: if (rsVal == 16'd0) modelNext = seqPc + sImm8;
         BNEZ: if (rsVal != 16'd0) modelNext = seqPc + sImm8;
         BLTZ: if (rsVal[15]) modelNext = seqPc + sImm8;
         BGEZ: if (!rsVal[15]) modelNext = seqPc + sImm8;
         J:    modelNext = seqPc + sImm11;
         JR:   modelNext = rsVal + sImm8;
         default: ;
      endcase
   end

   assign expWrite = modelWrite && (phase == 2'd2) && !haltModel;

   // Shadow state retires on the model's own phase count
   always @(posedge clk) begin
      if (rst) begin
         phase     <= 2'd0;
         expPc     <= startPc;
         haltModel <= 1'b0;
         for (int i = 0; i < 8; i++)
            shadow[i] <= '0;
      end else begin
         phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
         if (!haltModel && phase == 2'd1 && op == HALT)
            haltModel <= 1'b1;                           // Halt state after execute
         if (!haltModel && phase == 2'd2) begin
            if (modelWrite)
               shadow[modelReg] <= modelData;
            expPc <= modelNext;
         end
      end
   end

   aReset: assert property (@(posedge clk) $past(rst) |-> (!wbEn && !halted))
      else begin
         errCount++;
         $display("[FAIL] wbEn expected 0 actual %h, halted expected 0 actual %h",
                  $sampled(wbEn), $sampled(halted));
      end

   // Fetch address holds for three cycles, then moves to the model's next pc
   aPc: assert property (@(posedge clk) disable iff (rst) instrAddr == expPc)
      else begin
         errCount++;
         $display("[FAIL] instrAddr expected %h actual %h",
                  $sampled(expPc), $sampled(instrAddr));
      end

   aWbEn: assert property (@(posedge clk) disable iff (rst) wbEn == expWrite)
      else begin
         errCount++;
         $display("[FAIL] wbEn expected %h actual %h", $sampled(expWrite), $sampled(wbEn));
      end

   aWbReg: assert property (@(posedge clk) disable iff (rst) expWrite |-> wbReg == modelReg)
      else begin
         errCount++;
         $display("[FAIL] wbReg expected %h actual %h", $sampled(modelReg), $sampled(wbReg));
      end

   aWbData: assert property (@(posedge clk) disable iff (rst) expWrite |-> wbData == modelData)
      else begin
         errCount++;
         $display("[FAIL] wbData expected %h actual %h",
                  $sampled(modelData), $sampled(wbData));
      end

   aHalt: assert property (@(posedge clk) disable iff (rst) halted == haltModel)
      else begin
         errCount++;
         $display("[FAIL] halted expected %h actual %h", $sampled(haltModel), $sampled(halted));
      end

   // ROM answers from the address 1 ns after the edge
   always @(posedge clk) begin
      #1;
      instr = romWord(instrAddr);
   end

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("Timeout after %0d cycles, the program did not reach its end", cycleCount);
         $display("Test failed");
         $finish;
      end
   end

   task automatic runUntil(input logic [15:0] addr);
      while (instrAddr !== addr) begin
         @(posedge clk);
         #1;                                             // Pc has settled by now
      end
   endtask

   task automatic reportTest(input string name);
      if (errCount == errMark) begin
         passCount++;
         $display("%-24s passed", name);
      end else begin
         failCount++;
         $display("%-24s had %0d errors", name, errCount - errMark);
      end
      errMark = errCount;
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      instr      = '0;
      cycleCount = 0;
      errCount   = 0;
      errMark    = 0;
      passCount  = 0;
      failCount  = 0;
      lfsr       = 16'd55156;
      for (int i = 0; i < 6; i++)
         drawBits(5, immPool[i]);
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      runUntil(16'h0042);
      reportTest("reset and fetch timing");
      runUntil(16'h004C);
      reportTest("immediate ALU");
      runUntil(16'h0054);
      reportTest("R-format ALU");
      runUntil(16'h0070);
      reportTest("branches");
      runUntil(16'h007A);
      reportTest("jumps");
      while (!halted) begin
         @(posedge clk);
         #1;
      end
      repeat (6) @(posedge clk);                         // Pc must stay put with no writes
      reportTest("halt");
      $display("Tests: %0d passed, %0d with errors, %0d assertion errors",
               passCount, failCount, errCount);
      if (errCount == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

/* wiscCore.f */
rtl/wiscPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/pcCounter.sv
rtl/execute.sv
rtl/controlFsm.sv
rtl/wiscCore.sv
test/wiscCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the core testbench with Verilator, verdict from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module wiscCoreTb -f wiscCore.f -o wiscCoreSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/wiscCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   echo "Simulation FAILED, see $LOG"
   exit 1
fi

echo "Simulation passed"
exit 0
